// ==== hw/llc_read_pkg.sv ====
// llc read path definitions
package llc_read_pkg;

  // geometry
  localparam int unsigned AddrWidth         = 16;
  localparam int unsigned DataWidth         = 32;
  localparam int unsigned IdWidth           = 4;
  localparam int unsigned LenWidth          = 8;
  localparam int unsigned NumWays           = 4;
  localparam int unsigned NumLines          = 16;
  localparam int unsigned NumBlocks         = 4;
  localparam int unsigned WayIdxWidth       = $clog2(NumWays); // binary way index
  // address slices, low to high
  localparam int unsigned ByteOffsetLength  = 2;
  localparam int unsigned BlockOffsetLength = 2;
  localparam int unsigned IndexLength       = 4;
  localparam int unsigned MetaDepth         = 3; // in-flight beats toward the storage

  // returned in place of data on error beats
  localparam logic [DataWidth-1:0] LlcVersion = 32'h0001_0003;

  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [DataWidth-1:0]         data_t;
  typedef logic [IdWidth-1:0]           id_t;
  typedef logic [LenWidth-1:0]          len_t; // beats minus one
  typedef logic [WayIdxWidth-1:0]       way_ind_t;
  typedef logic [IndexLength-1:0]       index_t;
  typedef logic [BlockOffsetLength-1:0] blk_off_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } burst_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_t;

  // read descriptor from the cache front end
  typedef struct packed {
    id_t      id;
    addr_t    addr;
    len_t     len;
    logic [2:0] size;    // log2 of bytes per beat
    burst_t   burst;
    resp_t    resp;
    logic     last;      // descriptor closes the AXI burst
    way_ind_t way_ind;
  } llc_desc_t;

  typedef struct packed {
    way_ind_t way_ind;
    index_t   line_addr;
    blk_off_t blk_offset;
  } way_req_t;

  typedef struct packed {
    way_ind_t way_ind;
    index_t   line_addr;
    blk_off_t blk_offset;
    data_t    data;
  } way_fill_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
    logic  last;
  } r_meta_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_beat_t;

  typedef struct packed {
    index_t   index;
    way_ind_t way_ind;
  } unlock_t;

endpackage

// ==== hw/llc_fifo.sv ====
// synchronous fifo
`timescale 1ns/10ps

module llc_fifo #(
  parameter int unsigned Width       = 8,
  parameter int unsigned Depth       = 4, // at least 2
  parameter bit          FallThrough = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  typedef logic [$clog2(Depth)-1:0]   ptr_t;
  typedef logic [$clog2(Depth+1)-1:0] cnt_t;

  logic [Width-1:0] mem_q [Depth];    // storage, no reset
  ptr_t             wr_ptr_q;
  ptr_t             rd_ptr_q;
  cnt_t             cnt_q;            // fill count
  logic             bypass;           // push goes straight to the pop side
  logic             do_push;
  logic             do_pop;

  // wrap at Depth, which need not be a power of two
  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? ptr_t'(0) : ptr + ptr_t'(1);
  endfunction

  assign full_o  = (cnt_q == cnt_t'(Depth));
  assign empty_o = (cnt_q == '0) && !(FallThrough && push_i); // ft shows incoming word
  assign data_o  = (FallThrough && (cnt_q == '0)) ? data_i : mem_q[rd_ptr_q];

  assign bypass  = FallThrough && (cnt_q == '0) && push_i && pop_i;
  assign do_push = push_i && !bypass;
  assign do_pop  = pop_i && !bypass;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i; // on full with pop, old head is read first
    end
  end

  // the producer must respect full unless it pops in the same cycle
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_o |-> !(push_i && !pop_i));

  // the consumer must wait for data
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// ==== hw/llc_data_store.sv ====
// llc data storage
`timescale 1ns/10ps

module llc_data_store (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // fill port as a plain strobe
  input  llc_read_pkg::way_fill_t              fill_i,
  input  logic                                 fill_valid_i,
  // read request
  input  llc_read_pkg::way_req_t               req_i,
  input  logic                                 req_valid_i,
  output logic                                 req_ready_o,
  // read data
  output logic [llc_read_pkg::DataWidth-1:0]   rdata_o,
  output logic                                 rdata_valid_o,
  input  logic                                 rdata_ready_i
);
  import llc_read_pkg::*;

  data_t mem_q [NumWays][NumLines][NumBlocks]; // way, line, word
  data_t rdata_q;                              // output register
  logic  rdata_valid_q;
  logic  rd_accept;
  logic  out_stall;                            // held word not yet taken

  assign out_stall     = rdata_valid_q && !rdata_ready_i;
  assign req_ready_o   = !fill_valid_i && !out_stall; // fill wins over reads
  assign rd_accept     = req_valid_i && req_ready_o;
  assign rdata_o       = rdata_q;
  assign rdata_valid_o = rdata_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_valid_q <= 1'b0;
    end else if (rd_accept) begin
      rdata_valid_q <= 1'b1;  // data one cycle after accept
    end else if (rdata_ready_i) begin
      rdata_valid_q <= 1'b0;  // taken with nothing new behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      mem_q[fill_i.way_ind][fill_i.line_addr][fill_i.blk_offset] <= fill_i.data;
    end
    if (rd_accept) begin
      rdata_q <= mem_q[req_i.way_ind][req_i.line_addr][req_i.blk_offset];
    end
  end

  // a held word stays put until the unit takes it
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_stall |=> (rdata_valid_o && $stable(rdata_o)));

endmodule

// ==== hw/llc_burst_counter.sv ====
// burst address counter
`timescale 1ns/10ps

module llc_burst_counter (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      load_i,   // take a new descriptor
  input  llc_read_pkg::llc_desc_t   desc_i,
  input  logic                      step_i,   // one request issued, not the last
  output llc_read_pkg::addr_t       addr_o,
  output llc_read_pkg::len_t        len_o,
  output logic                      final_o
);
  import llc_read_pkg::*;

  addr_t      addr_q;   // current beat address
  len_t       len_q;    // beats left after this one
  logic [2:0] size_q;
  burst_t     burst_q;
  addr_t      incr;     // bytes per beat

  assign incr    = addr_t'(1) << size_q;
  assign addr_o  = addr_q;
  assign len_o   = len_q;
  assign final_o = (len_q == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q  <= '0;
      len_q   <= '0;
      size_q  <= '0;
      burst_q <= BURST_FIXED;
    end else if (load_i) begin
      addr_q  <= desc_i.addr;
      len_q   <= desc_i.len;
      size_q  <= desc_i.size;
      burst_q <= desc_i.burst;
    end else if (step_i) begin
      len_q <= len_q - len_t'(1);
      if (burst_q == BURST_INCR) begin
        addr_q <= addr_q + incr; // fixed keeps its address
      end
    end
  end

  // controller stops stepping once the last beat is reached
  a_no_step_past_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    step_i |-> !final_o);

endmodule

// ==== hw/llc_read_ctrl.sv ====
// read unit controller
`timescale 1ns/10ps

module llc_read_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  // descriptor handshake
  input  logic desc_valid_i,
  output logic desc_ready_o,
  output logic load_o,        // capture descriptor in counter and regs
  // burst counter
  input  logic final_i,       // current beat is the last one
  output logic step_o,
  // metadata fifo room
  input  logic meta_full_i,
  // line lock
  input  logic unlock_gnt_i,
  output logic unlock_req_o,
  // storage request handshake
  output logic req_valid_o,
  input  logic req_ready_i
);

  typedef enum logic {
    ST_IDLE,
    ST_BUSY
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   issue;              // request accepted by the storage

  assign desc_ready_o = (state_q == ST_IDLE);
  assign load_o       = desc_ready_o && desc_valid_i;

  // only issue with room for the metadata and the grant held
  assign req_valid_o  = (state_q == ST_BUSY) && !meta_full_i && unlock_gnt_i;
  assign issue        = req_valid_o && req_ready_i;
  assign step_o       = issue && !final_i;
  assign unlock_req_o = issue && final_i;  // one pulse per descriptor

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (load_o) begin
          state_d = ST_BUSY;
        end
      end
      ST_BUSY: begin
        if (unlock_req_o) begin
          state_d = ST_IDLE; // next descriptor one cycle later
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the unlock pulse lasts a single cycle
  a_unlock_one_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    unlock_req_o |=> !unlock_req_o);

endmodule

// ==== hw/llc_read_unit.sv ====
// llc read unit
`timescale 1ns/10ps

module llc_read_unit (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // descriptor in
  input  llc_read_pkg::llc_desc_t            desc_i,
  input  logic                               desc_valid_i,
  output logic                               desc_ready_o,
  // r channel out
  output llc_read_pkg::r_beat_t              r_chan_o,
  output logic                               r_chan_valid_o,
  input  logic                               r_chan_ready_i,
  // requests to the storage
  output llc_read_pkg::way_req_t             way_req_o,
  output logic                               way_req_valid_o,
  input  logic                               way_req_ready_i,
  // data from the storage
  input  logic [llc_read_pkg::DataWidth-1:0] way_rsp_i,
  input  logic                               way_rsp_valid_i,
  output logic                               way_rsp_ready_o,
  // line unlock
  output llc_read_pkg::unlock_t              unlock_o,
  output logic                               unlock_req_o,
  input  logic                               unlock_gnt_i
);
  import llc_read_pkg::*;

  r_meta_t  desc_meta_q;      // id, resp and burst last of the descriptor
  way_ind_t way_q;
  logic     load;
  logic     step;
  logic     beat_final;
  addr_t    beat_addr;
  len_t     beats_left;
  index_t   index;
  // metadata fifo
  r_meta_t  meta_in;
  r_meta_t  meta_out;
  logic     meta_push;
  logic     meta_pop;
  logic     meta_full;
  logic     meta_empty;
  // r fifo
  r_beat_t  r_in;
  logic     r_push;
  logic     r_pop;
  logic     r_full;
  logic     r_empty;

  always_ff @(posedge clk_i) begin
    if (load) begin
      desc_meta_q <= '{id: desc_i.id, resp: desc_i.resp, last: desc_i.last};
      way_q       <= desc_i.way_ind;
    end
  end

  assign index     = beat_addr[ByteOffsetLength + BlockOffsetLength +: IndexLength];
  assign way_req_o = '{
    way_ind:    way_q,
    line_addr:  index,
    blk_offset: beat_addr[ByteOffsetLength +: BlockOffsetLength]
  };
  assign unlock_o  = '{index: index, way_ind: way_q}; // line of the final beat

  // last only on the closing beat of a last descriptor
  assign meta_in   = '{
    id:   desc_meta_q.id,
    resp: desc_meta_q.resp,
    last: desc_meta_q.last && (beats_left == '0)
  };
  assign meta_push       = way_req_valid_o && way_req_ready_i;
  assign meta_pop        = r_push;             // meta leaves with its data word

  assign way_rsp_ready_o = !r_full && !meta_empty;
  assign r_push          = way_rsp_valid_i && way_rsp_ready_o;
  assign r_in            = '{
    id:   meta_out.id,
    data: (meta_out.resp == RESP_OKAY) ? way_rsp_i : LlcVersion,
    resp: meta_out.resp,
    last: meta_out.last
  };

  assign r_chan_valid_o  = !r_empty;
  assign r_pop           = r_chan_valid_o && r_chan_ready_i;

  llc_read_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .desc_valid_i (desc_valid_i),
    .desc_ready_o (desc_ready_o),
    .load_o       (load),
    .final_i      (beat_final),
    .step_o       (step),
    .meta_full_i  (meta_full),
    .unlock_gnt_i (unlock_gnt_i),
    .unlock_req_o (unlock_req_o),
    .req_valid_o  (way_req_valid_o),
    .req_ready_i  (way_req_ready_i)
  );

  llc_burst_counter u_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (load),
    .desc_i  (desc_i),
    .step_i  (step),
    .addr_o  (beat_addr),
    .len_o   (beats_left),
    .final_o (beat_final)
  );

  // registered, storage answers a cycle later anyway
  llc_fifo #(
    .Width       ($bits(r_meta_t)),
    .Depth       (MetaDepth),
    .FallThrough (1'b0)
  ) u_meta_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (meta_push),
    .data_i  (meta_in),
    .pop_i   (meta_pop),
    .data_o  (meta_out),
    .full_o  (meta_full),
    .empty_o (meta_empty)
  );

  // fall-through, returned word can leave in the same cycle
  llc_fifo #(
    .Width       ($bits(r_beat_t)),
    .Depth       (NumBlocks),
    .FallThrough (1'b1)
  ) u_r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (r_push),
    .data_i  (r_in),
    .pop_i   (r_pop),
    .data_o  (r_chan_o),
    .full_o  (r_full),
    .empty_o (r_empty)
  );

endmodule

// ==== hw/llc_read_top.sv ====
// llc read path top
`timescale 1ns/10ps

module llc_read_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  llc_read_pkg::llc_desc_t   desc_i,
  input  logic                      desc_valid_i,
  output logic                      desc_ready_o,
  input  llc_read_pkg::way_fill_t   fill_i,
  input  logic                      fill_valid_i,
  output llc_read_pkg::r_beat_t     r_chan_o,
  output logic                      r_chan_valid_o,
  input  logic                      r_chan_ready_i,
  output llc_read_pkg::unlock_t     unlock_o,
  output logic                      unlock_req_o,
  input  logic                      unlock_gnt_i
);
  import llc_read_pkg::*;

  way_req_t way_req;        // unit to storage
  logic     way_req_valid;
  logic     way_req_ready;
  data_t    way_rdata;      // storage to unit
  logic     way_rdata_valid;
  logic     way_rdata_ready;

  llc_read_unit u_read_unit (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .desc_i          (desc_i),
    .desc_valid_i    (desc_valid_i),
    .desc_ready_o    (desc_ready_o),
    .r_chan_o        (r_chan_o),
    .r_chan_valid_o  (r_chan_valid_o),
    .r_chan_ready_i  (r_chan_ready_i),
    .way_req_o       (way_req),
    .way_req_valid_o (way_req_valid),
    .way_req_ready_i (way_req_ready),
    .way_rsp_i       (way_rdata),
    .way_rsp_valid_i (way_rdata_valid),
    .way_rsp_ready_o (way_rdata_ready),
    .unlock_o        (unlock_o),
    .unlock_req_o    (unlock_req_o),
    .unlock_gnt_i    (unlock_gnt_i)
  );

  llc_data_store u_data_store (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fill_i        (fill_i),
    .fill_valid_i  (fill_valid_i),
    .req_i         (way_req),
    .req_valid_i   (way_req_valid),
    .req_ready_o   (way_req_ready),
    .rdata_o       (way_rdata),
    .rdata_valid_o (way_rdata_valid),
    .rdata_ready_i (way_rdata_ready)
  );

endmodule

// ==== tb/llc_read_tasks.svh ====
// directed read path tests

  // expected beats and unlock target of one descriptor
  task automatic expect_desc(input llc_desc_t d);
    addr_t    a;
    index_t   idx;
    blk_off_t blk;
    r_beat_t  b;
    int       i;
    a = d.addr;
    for (i = 0; i <= int'(d.len); i++) begin
      idx    = a[ByteOffsetLength + BlockOffsetLength +: IndexLength]; // high bits drop off
      blk    = a[ByteOffsetLength +: BlockOffsetLength];
      b.id   = d.id;
      b.data = (d.resp == RESP_OKAY) ? model[d.way_ind][idx][blk] : LlcVersion;
      b.resp = d.resp;
      b.last = d.last && (i == int'(d.len)); // only the closing beat
      exp_q.push_back(b);
      if (d.burst == BURST_INCR) begin
        a = a + (addr_t'(1) << d.size);
      end
    end
    unlock_exp_q.push_back('{index: idx, way_ind: d.way_ind}); // line of final beat
  endtask

  function automatic llc_desc_t make_desc(input id_t id, input addr_t addr, input len_t len,
                                          input logic [2:0] size, input burst_t burst,
                                          input resp_t resp, input logic last,
                                          input way_ind_t way);
    return '{id: id, addr: addr, len: len, size: size, burst: burst, resp: resp,
             last: last, way_ind: way};
  endfunction

  task automatic send_desc(input llc_desc_t d);
    expect_desc(d);
    @(posedge clk);
    desc       <= d;
    desc_valid <= 1'b1;
    @(posedge clk);
    while (!desc_ready) @(posedge clk); // taken on a ready edge
    desc_valid <= 1'b0;
    descs_sent++;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || unlock_exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  task automatic idle_after_reset();
    @(posedge clk);
    if (r_chan_valid !== 1'b0) report_mismatch("r_chan_valid_o", r_chan_valid, 1'b0);
    if (unlock_req !== 1'b0) report_mismatch("unlock_req_o", unlock_req, 1'b0);
    if (desc_ready !== 1'b1) report_mismatch("desc_ready_o", desc_ready, 1'b1);
  endtask

  task automatic single_beat_reads();
    send_desc(make_desc(4'h3, 16'h0104, 8'd0, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd1));
    send_desc(make_desc(4'h9, 16'h02a8, 8'd0, 3'd2, BURST_INCR, RESP_OKAY, 1'b0, 2'd0));
    wait_drain();
  endtask

  // index f rolls over into index 0 mid burst
  task automatic incr_line_cross();
    send_desc(make_desc(4'h4, 16'h00f8, 8'd7, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd3));
    send_desc(make_desc(4'h5, 16'h0010, 8'd3, 3'd1, BURST_INCR, RESP_OKAY, 1'b1, 2'd0)); // half words
    wait_drain();
  endtask

  task automatic fixed_burst_reads();
    send_desc(make_desc(4'h6, 16'h0024, 8'd3, 3'd2, BURST_FIXED, RESP_OKAY, 1'b1, 2'd2));
    wait_drain();
  endtask

  // error beats carry the version word while ids stay in order
  task automatic error_resp_order();
    send_desc(make_desc(4'h7, 16'h0040, 8'd2, 3'd2, BURST_INCR, RESP_SLVERR, 1'b1, 2'd1));
    send_desc(make_desc(4'h8, 16'h0080, 8'd2, 3'd2, BURST_INCR, RESP_DECERR, 1'b1, 2'd3));
    send_desc(make_desc(4'h9, 16'h00c4, 8'd1, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd1));
    wait_drain();
  endtask

  task automatic random_backpressure();
    @(posedge clk);
    rand_ready_on <= 1'b1;
    send_desc(make_desc(4'ha, 16'h0030, 8'd7, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd0));
    send_desc(make_desc(4'hb, 16'h0070, 8'd7, 3'd2, BURST_INCR, RESP_OKAY, 1'b0, 2'd1));
    send_desc(make_desc(4'hc, 16'h00e0, 8'd7, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd2));
    wait_drain();
    rand_ready_on <= 1'b0;
  endtask

  // nothing may issue while the grant is low
  task automatic grant_low_stall();
    @(posedge clk);
    unlock_gnt <= 1'b0;
    send_desc(make_desc(4'hd, 16'h0158, 8'd3, 3'd2, BURST_INCR, RESP_OKAY, 1'b1, 2'd2));
    repeat (12) begin
      @(posedge clk);
      if (r_chan_valid !== 1'b0 || unlock_req !== 1'b0) begin
        errors++;
        $display("read issued at %0t ns while unlock_gnt_i was held low", $time);
      end
    end
    unlock_gnt <= 1'b1;
    wait_drain();
  endtask

// ==== tb/tb_llc_read_top.sv ====
// llc read path testbench
`timescale 1ns/10ps

module tb_llc_read_top;
  import llc_read_pkg::*;

  localparam int TotalBeats = 54;                   // r beats over all directed tests
  localparam int CycleLimit = 4 * TotalBeats + 500; // fill pass fits in the 500

  logic      clk = 1'b0;
  logic      rst_n;
  llc_desc_t desc;
  logic      desc_valid;
  logic      desc_ready;
  way_fill_t fill;
  logic      fill_valid;
  r_beat_t   r_chan;
  logic      r_chan_valid;
  logic      r_chan_ready = 1'b1;
  unlock_t   unlock;
  logic      unlock_req;
  logic      unlock_gnt;

  data_t     model [NumWays][NumLines][NumBlocks]; // copy of the storage contents
  r_beat_t   exp_q [$];         // expected r beats with the oldest first
  unlock_t   unlock_exp_q [$];  // one entry per descriptor
  r_beat_t   mon_beat;
  unlock_t   mon_unlock;
  integer    seed = 67827;
  logic      rand_ready_on;     // random back-pressure on the r channel
  int        hold_cnt = 0;      // cycles left in a ready-low stretch
  int        rnd;
  int        errors = 0;
  int        beats_seen = 0;
  int        unlocks_seen = 0;
  int        descs_sent = 0;
  int        cycles = 0;

  always #4 clk = ~clk; // 8 ns period

  llc_read_top u_llc_read_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .desc_i         (desc),
    .desc_valid_i   (desc_valid),
    .desc_ready_o   (desc_ready),
    .fill_i         (fill),
    .fill_valid_i   (fill_valid),
    .r_chan_o       (r_chan),
    .r_chan_valid_o (r_chan_valid),
    .r_chan_ready_i (r_chan_ready),
    .unlock_o       (unlock),
    .unlock_req_o   (unlock_req),
    .unlock_gnt_i   (unlock_gnt)
  );

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
  endtask

  `include "llc_read_tasks.svh"

  // load every word once and keep the same words in the model
  task automatic fill_storage();
    data_t w;
    int    way;
    int    line;
    int    blk;
    for (way = 0; way < NumWays; way++) begin
      for (line = 0; line < NumLines; line++) begin
        for (blk = 0; blk < NumBlocks; blk++) begin
          w = $random(seed);
          model[way][line][blk] = w;
          @(posedge clk);
          fill <= '{way_ind: way_ind_t'(way), line_addr: index_t'(line),
                    blk_offset: blk_off_t'(blk), data: w};
          fill_valid <= 1'b1;
        end
      end
    end
    @(posedge clk);
    fill_valid <= 1'b0;
  endtask

  // random r channel ready with long low stretches when enabled
  always @(posedge clk) begin
    if (!rand_ready_on) begin
      r_chan_ready <= 1'b1;
      hold_cnt     <= NumBlocks + 4; // first stretch right after enable
    end else if (hold_cnt != 0) begin
      r_chan_ready <= 1'b0;
      hold_cnt     <= hold_cnt - 1;
    end else begin
      rnd = $random(seed);
      if (rnd[3:0] == 4'h0) begin
        hold_cnt <= NumBlocks + 2; // outlasts the r fifo
      end
      r_chan_ready <= rnd[0];
    end
  end

  // r beats in order against the expected queue
  always @(posedge clk) begin
    if (rst_n && r_chan_valid && r_chan_ready) begin
      beats_seen++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected r beat at %0t ns with nothing left to expect", $time);
      end else begin
        mon_beat = exp_q.pop_front();
        if (r_chan.id !== mon_beat.id) report_mismatch("r_chan_o.id", r_chan.id, mon_beat.id);
        if (r_chan.data !== mon_beat.data)
          report_mismatch("r_chan_o.data", r_chan.data, mon_beat.data);
        if (r_chan.resp !== mon_beat.resp)
          report_mismatch("r_chan_o.resp", r_chan.resp, mon_beat.resp);
        if (r_chan.last !== mon_beat.last)
          report_mismatch("r_chan_o.last", r_chan.last, mon_beat.last);
      end
    end
  end

  // one unlock pulse per descriptor on its final line
  always @(posedge clk) begin
    if (rst_n && unlock_req) begin
      unlocks_seen++;
      if (unlock_exp_q.size() == 0) begin
        errors++;
        $display("extra unlock pulse at %0t ns, no descriptor was waiting", $time);
      end else begin
        mon_unlock = unlock_exp_q.pop_front();
        if (unlock.index !== mon_unlock.index)
          report_mismatch("unlock_o.index", unlock.index, mon_unlock.index);
        if (unlock.way_ind !== mon_unlock.way_ind)
          report_mismatch("unlock_o.way_ind", unlock.way_ind, mon_unlock.way_ind);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CycleLimit) begin
      $display("timeout after %0d cycles, beats still expected: %0d", CycleLimit, exp_q.size());
      $display("errors: %0d, beats checked: %0d, unlock pulses: %0d",
               errors, beats_seen, unlocks_seen);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    rst_n         = 1'b0;
    desc          = '0;
    desc_valid    = 1'b0;
    fill          = '0;
    fill_valid    = 1'b0;
    unlock_gnt    = 1'b1;
    rand_ready_on = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    idle_after_reset();
    fill_storage();
    single_beat_reads();
    incr_line_cross();
    fixed_burst_reads();
    error_resp_order();
    random_backpressure();
    grant_low_stall();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected r beats never arrived", exp_q.size());
    end
    if (unlocks_seen != descs_sent) begin
      errors++;
      $display("%0d unlock pulses seen for %0d descriptors", unlocks_seen, descs_sent);
    end
    $display("errors: %0d, beats checked: %0d, unlock pulses: %0d",
             errors, beats_seen, unlocks_seen);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+tb
hw/llc_read_pkg.sv
hw/llc_fifo.sv
hw/llc_data_store.sv
hw/llc_burst_counter.sv
hw/llc_read_ctrl.sv
hw/llc_read_unit.sv
hw/llc_read_top.sv
tb/tb_llc_read_top.sv
